//--- include/sha_settings.svh
`ifndef SHA_SETTINGS_SVH
`define SHA_SETTINGS_SVH

// Rounds in one SHA-256 compression, and so the length of each round chain.
`define SHA_ROUNDS 64

// The midstate travels alongside the first chain for this many cycles.
`define SHA_HASH1_DELAY `SHA_ROUNDS

// First chain, pad stage, second chain and the output register.
// With 64 rounds this comes to 130 cycles.
`define SHA_LATENCY (2 * `SHA_ROUNDS + 2)

// Width of the final double hash.
`define SHA_DIGEST_BITS 256

`endif

//--- rtl/sha_pkg.sv
`include "sha_settings.svh"

package sha_pkg;

	typedef logic [31:0] word_t;

	// Field a lands in the most significant word when the struct is packed.
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} hash_state_t;

	// Message window. Element 0 is the oldest word and is consumed first.
	typedef word_t [15:0] block_t;

	typedef logic [`SHA_DIGEST_BITS-1:0] digest_t;

	localparam word_t K_TABLE [`SHA_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word_t sha_k(input int unsigned round);
		return K_TABLE[round];
	endfunction

	function automatic hash_state_t sha_init_state();
		hash_state_t s;
		s.a = 32'h6a09e667;
		s.b = 32'hbb67ae85;
		s.c = 32'h3c6ef372;
		s.d = 32'ha54ff53a;
		s.e = 32'h510e527f;
		s.f = 32'h9b05688c;
		s.g = 32'h1f83d9ab;
		s.h = 32'h5be0cd19;
		return s;
	endfunction

	// Each word wraps on its own, so no carry crosses from one field into the next.
	function automatic hash_state_t sha_add_state(input hash_state_t x, input hash_state_t y);
		hash_state_t s;
		s.a = x.a + y.a;
		s.b = x.b + y.b;
		s.c = x.c + y.c;
		s.d = x.d + y.d;
		s.e = x.e + y.e;
		s.f = x.f + y.f;
		s.g = x.g + y.g;
		s.h = x.h + y.h;
		return s;
	endfunction

	function automatic digest_t sha_state_to_digest(input hash_state_t s);
		return {s.a, s.b, s.c, s.d, s.e, s.f, s.g, s.h};
	endfunction

	function automatic word_t sha_rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t sha_big_sigma0(input word_t x);
		return sha_rotr(x, 2) ^ sha_rotr(x, 13) ^ sha_rotr(x, 22);
	endfunction

	function automatic word_t sha_big_sigma1(input word_t x);
		return sha_rotr(x, 6) ^ sha_rotr(x, 11) ^ sha_rotr(x, 25);
	endfunction

	function automatic word_t sha_small_sigma0(input word_t x);
		return sha_rotr(x, 7) ^ sha_rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t sha_small_sigma1(input word_t x);
		return sha_rotr(x, 17) ^ sha_rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t sha_ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t sha_maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage : sha_pkg

//--- rtl/sha_delay_line.sv
module sha_delay_line #(
	parameter type T = logic,
	parameter int DELAY = 1,
	parameter bit RESETTABLE = 1'b0
) (
	input  logic clk,
	input  logic reset_i,
	input  T     data_i,
	output T     data_o
);

	T stages_q [DELAY];

	// Entry 0 takes the input, so the output is exactly DELAY edges behind it.
	always_ff @(posedge clk) begin
		if (RESETTABLE && reset_i) begin
			for (int i = 0; i < DELAY; i++) begin
				stages_q[i] <= '0;
			end
		end else begin
			stages_q[0] <= data_i;
			for (int i = 1; i < DELAY; i++) begin
				stages_q[i] <= stages_q[i-1];
			end
		end
	end

	assign data_o = stages_q[DELAY-1];

endmodule : sha_delay_line

//--- rtl/sha_round_stage.sv
module sha_round_stage #(
	parameter int unsigned ROUND = 0,
	parameter bit EXPAND = 1'b0
) (
	input  logic                clk,
	input  sha_pkg::hash_state_t state_i,
	input  sha_pkg::block_t      window_i,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::block_t      window_o
);

	sha_pkg::word_t      expanded;
	sha_pkg::word_t      round_word;
	sha_pkg::word_t      t1;
	sha_pkg::word_t      t2;
	sha_pkg::hash_state_t next_state;
	sha_pkg::block_t      next_window;

	// With the expander the window holds W[t-16] up to W[t-1], so the schedule
	// formula picks words 14, 9, 1 and 0 to build W[t].
	assign expanded = sha_pkg::sha_small_sigma1(window_i[14]) + window_i[9]
		+ sha_pkg::sha_small_sigma0(window_i[1]) + window_i[0];

	// The word used by this round is also the word that enters the top of the window.
	// Without the expander word 0 simply rotates round, so after the first 16
	// stages the window is back to W[0] up to W[15] in order.
	assign round_word = EXPAND ? expanded : window_i[0];

	always_comb begin
		t1 = state_i.h + sha_pkg::sha_big_sigma1(state_i.e)
			+ sha_pkg::sha_ch(state_i.e, state_i.f, state_i.g)
			+ sha_pkg::sha_k(ROUND) + round_word;
		t2 = sha_pkg::sha_big_sigma0(state_i.a)
			+ sha_pkg::sha_maj(state_i.a, state_i.b, state_i.c);

		next_state.a = t1 + t2;
		next_state.b = state_i.a;
		next_state.c = state_i.b;
		next_state.d = state_i.c;
		next_state.e = state_i.d + t1;
		next_state.f = state_i.e;
		next_state.g = state_i.f;
		next_state.h = state_i.g;
	end

	always_comb begin
		for (int i = 0; i < 15; i++) begin
			next_window[i] = window_i[i+1];
		end
		next_window[15] = round_word;
	end

	always_ff @(posedge clk) begin
		state_o  <= next_state;
		window_o <= next_window;
	end

endmodule : sha_round_stage

//--- rtl/sha_pad_stage.sv
module sha_pad_stage (
	input  logic                clk,
	input  sha_pkg::hash_state_t state_i,
	input  sha_pkg::hash_state_t midstate_i,
	output sha_pkg::block_t      block_o
);

	sha_pkg::hash_state_t first_hash;
	sha_pkg::block_t      padded;

	// Adding the midstate back completes the first hash.
	assign first_hash = sha_pkg::sha_add_state(state_i, midstate_i);

	// The 256-bit digest fills exactly half a chunk. The rest is the single
	// pad bit, zeros, and a message length of 256 bits in the last word.
	always_comb begin
		padded[0] = first_hash.a;
		padded[1] = first_hash.b;
		padded[2] = first_hash.c;
		padded[3] = first_hash.d;
		padded[4] = first_hash.e;
		padded[5] = first_hash.f;
		padded[6] = first_hash.g;
		padded[7] = first_hash.h;
		padded[8] = 32'h80000000;
		for (int i = 9; i < 15; i++) begin
			padded[i] = '0;
		end
		padded[15] = 32'd256;
	end

	always_ff @(posedge clk) begin
		block_o <= padded;
	end

endmodule : sha_pad_stage

//--- rtl/sha_double_hash_core.sv
`include "sha_settings.svh"

module sha_double_hash_core (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 valid_i,
	input  logic                 newblock_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  sha_pkg::block_t      block_i,
	output logic                 valid_o,
	output sha_pkg::digest_t     doublehash_o
);

	// Rounds below this index only rotate the window; the schedule takes over after.
	localparam int unsigned EXPAND_FROM = 16;

	sha_pkg::hash_state_t midstate_q;
	sha_pkg::hash_state_t midstate_eff;
	sha_pkg::hash_state_t midstate_delayed;

	sha_pkg::hash_state_t hash1_state [`SHA_ROUNDS+1];
	sha_pkg::block_t      hash1_window [`SHA_ROUNDS];
	sha_pkg::hash_state_t hash2_state [`SHA_ROUNDS+1];
	sha_pkg::block_t      hash2_window [`SHA_ROUNDS];

	// A new midstate applies to the item that brings it, so the register is
	// bypassed in that cycle.
	always_ff @(posedge clk) begin
		if (reset_i) begin
			midstate_q <= '0;
		end else if (valid_i && newblock_i) begin
			midstate_q <= midstate_i;
		end
	end

	assign midstate_eff = (valid_i && newblock_i) ? midstate_i : midstate_q;

	// Each item carries its own copy of the midstate, so a switch mid-stream
	// does not disturb items already in the first chain.
	sha_delay_line #(
		.T(sha_pkg::hash_state_t),
		.DELAY(`SHA_HASH1_DELAY),
		.RESETTABLE(1'b0)
	) midstate_delay_i (
		.clk,
		.reset_i,
		.data_i(midstate_eff),
		.data_o(midstate_delayed)
	);

	sha_delay_line #(
		.T(logic),
		.DELAY(`SHA_LATENCY),
		.RESETTABLE(1'b1)
	) valid_delay_i (
		.clk,
		.reset_i,
		.data_i(valid_i),
		.data_o(valid_o)
	);

	assign hash1_state[0]  = midstate_eff;
	assign hash1_window[0] = block_i;

	for (genvar i = 0; i < `SHA_ROUNDS; i++) begin : g_hash1
		if (i < `SHA_ROUNDS - 1) begin : g_pass
			sha_round_stage #(
				.ROUND(i),
				.EXPAND(i >= EXPAND_FROM)
			) sha_round_stage_i (
				.clk,
				.state_i(hash1_state[i]),
				.window_i(hash1_window[i]),
				.state_o(hash1_state[i+1]),
				.window_o(hash1_window[i+1])
			);
		end else begin : g_last
			// Only the state goes on from the last round, so its window stays open.
			sha_round_stage #(
				.ROUND(i),
				.EXPAND(i >= EXPAND_FROM)
			) sha_round_stage_i (
				.clk,
				.state_i(hash1_state[i]),
				.window_i(hash1_window[i]),
				.state_o(hash1_state[i+1]),
				.window_o()
			);
		end
	end

	sha_pad_stage sha_pad_stage_i (
		.clk,
		.state_i(hash1_state[`SHA_ROUNDS]),
		.midstate_i(midstate_delayed),
		.block_o(hash2_window[0])
	);

	// The second hash always starts from the standard initial state.
	assign hash2_state[0] = sha_pkg::sha_init_state();

	for (genvar i = 0; i < `SHA_ROUNDS; i++) begin : g_hash2
		if (i < `SHA_ROUNDS - 1) begin : g_pass
			sha_round_stage #(
				.ROUND(i),
				.EXPAND(i >= EXPAND_FROM)
			) sha_round_stage_i (
				.clk,
				.state_i(hash2_state[i]),
				.window_i(hash2_window[i]),
				.state_o(hash2_state[i+1]),
				.window_o(hash2_window[i+1])
			);
		end else begin : g_last
			sha_round_stage #(
				.ROUND(i),
				.EXPAND(i >= EXPAND_FROM)
			) sha_round_stage_i (
				.clk,
				.state_i(hash2_state[i]),
				.window_i(hash2_window[i]),
				.state_o(hash2_state[i+1]),
				.window_o()
			);
		end
	end

	// The second hash adds its initial state back before the digest is registered.
	always_ff @(posedge clk) begin
		doublehash_o <= sha_pkg::sha_state_to_digest(
			sha_pkg::sha_add_state(hash2_state[`SHA_ROUNDS], sha_pkg::sha_init_state()));
	end

endmodule : sha_double_hash_core

//--- tb/tb_sha_double_hash.sv
`include "sha_settings.svh"

module tb_sha_double_hash;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STREAM_ITEMS = 200;
	localparam int GAP_CYCLES = 150;
	localparam int RESET_STREAM = 40;
	localparam int IDLE_CYCLES = 20;
	localparam int AFTER_RESET_ITEMS = 10;
	localparam int STIM_CYCLES = 3 + 2 + STREAM_ITEMS + GAP_CYCLES + RESET_STREAM + 4
		+ IDLE_CYCLES + 2 * AFTER_RESET_ITEMS + 2;
	localparam int CYCLE_LIMIT = STIM_CYCLES + `SHA_LATENCY + 50;

	// Published SHA-256 of the three bytes "abc".
	localparam sha_pkg::digest_t ABC_SHA256 =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 valid;
	logic                 newblock;
	sha_pkg::hash_state_t midstate;
	sha_pkg::block_t      block;
	logic                 valid_out;
	sha_pkg::digest_t     doublehash;

	sha_pkg::word_t       k_ref [64];
	sha_pkg::hash_state_t iv_ref;
	sha_pkg::hash_state_t ref_midstate;
	logic [31:0]          lfsr_state = 32'd86;
	int                   cycle_count = 0;
	int                   digest_errors = 0;
	int                   valid_errors = 0;
	sha_pkg::digest_t     exp_digest_q [$];
	int                   exp_cycle_q [$];

	sha_double_hash_core sha_double_hash_core_i (
		.clk(clk),
		.reset_i(reset),
		.valid_i(valid),
		.newblock_i(newblock),
		.midstate_i(midstate),
		.block_i(block),
		.valid_o(valid_out),
		.doublehash_o(doublehash)
	);

	always #10 clk = ~clk;

	// Galois form, shifting right. The bit that falls out is the random bit.
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hD0000001;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = next_lfsr(lfsr_state);
		end
		return r;
	endfunction

	function automatic sha_pkg::hash_state_t random_state();
		logic [255:0] v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v = {v[223:0], take_bits(32)};
		end
		return sha_pkg::hash_state_t'(v);
	endfunction

	function automatic sha_pkg::block_t random_block();
		sha_pkg::block_t b;
		for (int i = 0; i < 16; i++) begin
			b[i] = take_bits(32);
		end
		return b;
	endfunction

	// First 32 bits of the fractional part, as the standard defines its constants.
	function automatic sha_pkg::word_t frac_word(input real x);
		real v;
		int hi;
		int lo;
		v = $floor((x - $floor(x)) * 4294967296.0);
		hi = $rtoi($floor(v / 65536.0));
		lo = $rtoi(v - hi * 65536.0);
		return {hi[15:0], lo[15:0]};
	endfunction

	task automatic init_constants();
		int found;
		int n;
		bit is_prime;
		real p;
		sha_pkg::word_t iv_words [8];
		found = 0;
		n = 2;
		while (found < 64) begin
			is_prime = 1'b1;
			for (int d = 2; d * d <= n; d++) begin
				if (n % d == 0) begin
					is_prime = 1'b0;
				end
			end
			if (is_prime) begin
				p = n;
				if (found < 8) begin
					iv_words[found] = frac_word($sqrt(p));
				end
				k_ref[found] = frac_word($pow(p, 1.0 / 3.0));
				found++;
			end
			n++;
		end
		iv_ref = {iv_words[0], iv_words[1], iv_words[2], iv_words[3],
			iv_words[4], iv_words[5], iv_words[6], iv_words[7]};
	endtask

	function automatic sha_pkg::word_t rotate_right(input sha_pkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic sha_pkg::digest_t state_digest(input sha_pkg::hash_state_t s);
		return {s.a, s.b, s.c, s.d, s.e, s.f, s.g, s.h};
	endfunction

	// One SHA-256 compression, written straight from the standard.
	function automatic sha_pkg::hash_state_t sha256_compress(input sha_pkg::hash_state_t s,
			input sha_pkg::block_t m);
		sha_pkg::word_t w [64];
		sha_pkg::hash_state_t v;
		sha_pkg::hash_state_t r;
		sha_pkg::word_t s0;
		sha_pkg::word_t s1;
		sha_pkg::word_t t1;
		sha_pkg::word_t t2;
		for (int t = 0; t < 64; t++) begin
			if (t < 16) begin
				w[t] = m[t];
			end else begin
				s0 = rotate_right(w[t-15], 7) ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3);
				s1 = rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19) ^ (w[t-2] >> 10);
				w[t] = w[t-16] + s0 + w[t-7] + s1;
			end
		end
		v = s;
		for (int t = 0; t < 64; t++) begin
			s1 = rotate_right(v.e, 6) ^ rotate_right(v.e, 11) ^ rotate_right(v.e, 25);
			t1 = v.h + s1 + ((v.e & v.f) ^ (~v.e & v.g)) + k_ref[t] + w[t];
			s0 = rotate_right(v.a, 2) ^ rotate_right(v.a, 13) ^ rotate_right(v.a, 22);
			t2 = s0 + ((v.a & v.b) ^ (v.a & v.c) ^ (v.b & v.c));
			v = {t1 + t2, v.a, v.b, v.c, v.d + t1, v.e, v.f, v.g};
		end
		r = {s.a + v.a, s.b + v.b, s.c + v.c, s.d + v.d,
			s.e + v.e, s.f + v.f, s.g + v.g, s.h + v.h};
		return r;
	endfunction

	// The first digest is 32 bytes, so the second message is one padded chunk.
	function automatic sha_pkg::digest_t sha_double_ref(input sha_pkg::hash_state_t mid,
			input sha_pkg::block_t blk);
		sha_pkg::hash_state_t h1;
		sha_pkg::block_t pad;
		h1 = sha256_compress(mid, blk);
		pad = '0;
		pad[0] = h1.a;
		pad[1] = h1.b;
		pad[2] = h1.c;
		pad[3] = h1.d;
		pad[4] = h1.e;
		pad[5] = h1.f;
		pad[6] = h1.g;
		pad[7] = h1.h;
		pad[8] = 32'h80000000;
		pad[15] = 32'd256;
		return state_digest(sha256_compress(iv_ref, pad));
	endfunction

	task automatic check_digest(input sha_pkg::digest_t got, input sha_pkg::digest_t exp,
			input string name);
		if (got !== exp) begin
			digest_errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input int queued);
		if (got !== exp) begin
			valid_errors++;
			$display("** Error at %0t: valid_o = %b, expected %b", $time, got, exp);
			if (exp) begin
				$display("An expected item did not arrive on time.");
			end else if (queued == 0) begin
				$display("valid_o rose while no item was queued.");
			end else begin
				$display("valid_o rose before the next queued item was due.");
			end
		end
	endtask

	// The item is taken at the next edge, so its output is due SHA_LATENCY counts later.
	task automatic drive_cycle(input logic v, input logic nb, input sha_pkg::hash_state_t ms,
			input sha_pkg::block_t blk);
		@(posedge clk);
		#2;
		valid = v;
		newblock = nb;
		midstate = ms;
		block = blk;
		if (v) begin
			if (nb) begin
				ref_midstate = ms;
			end
			exp_digest_q.push_back(sha_double_ref(ref_midstate, blk));
			exp_cycle_q.push_back(cycle_count + `SHA_LATENCY);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		reset = 1'b1;
		valid = 1'b0;
		newblock = 1'b0;
		@(posedge clk);
		#2;
		// Everything in flight is dropped and the midstate register is cleared.
		exp_digest_q.delete();
		exp_cycle_q.delete();
		ref_midstate = '0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped by timeout, %0d items never arrived.", exp_cycle_q.size());
			$display("Errors: %0d digest, %0d valid", digest_errors, valid_errors);
			$display("Something failed");
			$finish;
		end
	end

	// Outputs are sampled on the falling edge, well away from the DUT updates.
	always @(negedge clk) begin
		logic due;
		due = (exp_cycle_q.size() > 0) && (exp_cycle_q[0] == cycle_count);
		check_valid(valid_out, due, exp_cycle_q.size());
		if (due) begin
			if (valid_out === 1'b1) begin
				check_digest(doublehash, exp_digest_q[0], "doublehash_o");
			end
			void'(exp_digest_q.pop_front());
			void'(exp_cycle_q.pop_front());
		end
	end

	initial begin
		sha_pkg::block_t abc_block;
		logic [31:0] r;
		reset = 1'b1;
		valid = 1'b0;
		newblock = 1'b0;
		midstate = '0;
		block = '0;
		ref_midstate = '0;
		init_constants();

		// Padded "abc" as a single chunk. This also checks the reference itself.
		abc_block = '0;
		abc_block[0] = 32'h61626380;
		abc_block[15] = 32'h18;
		check_digest(state_digest(sha256_compress(iv_ref, abc_block)), ABC_SHA256,
			"reference SHA-256 of abc");

		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		drive_cycle(1'b1, 1'b1, iv_ref, abc_block);
		drive_cycle(1'b0, 1'b0, '0, '0);

		// Back to back, with a new midstate halfway through.
		for (int i = 0; i < STREAM_ITEMS; i++) begin
			drive_cycle(1'b1, (i == 0) || (i == STREAM_ITEMS / 2), random_state(),
				random_block());
		end

		for (int i = 0; i < GAP_CYCLES; i++) begin
			r = take_bits(3);
			drive_cycle(r[0], r[1] & r[2], random_state(), random_block());
		end

		for (int i = 0; i < RESET_STREAM; i++) begin
			drive_cycle(1'b1, 1'b0, random_state(), random_block());
		end
		apply_reset();
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			drive_cycle(1'b0, 1'b0, '0, '0);
		end

		// First with the cleared midstate, then with a fresh one.
		for (int i = 0; i < AFTER_RESET_ITEMS; i++) begin
			drive_cycle(1'b1, 1'b0, random_state(), random_block());
		end
		for (int i = 0; i <= AFTER_RESET_ITEMS; i++) begin
			drive_cycle(1'b1, i == 0, random_state(), random_block());
		end
		drive_cycle(1'b0, 1'b0, '0, '0);

		while (exp_cycle_q.size() > 0) begin
			@(posedge clk);
		end
		repeat (5) @(posedge clk);

		$display("Errors: %0d digest, %0d valid", digest_errors, valid_errors);
		if (digest_errors + valid_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule : tb_sha_double_hash

//--- tb.f
+incdir+include
rtl/sha_pkg.sv
rtl/sha_delay_line.sv
rtl/sha_round_stage.sv
rtl/sha_pad_stage.sv
rtl/sha_double_hash_core.sv
tb/tb_sha_double_hash.sv
